// File: src/led_cal_pkg.sv
package led_cal_pkg;

    // pixel stream geometry, sized for a 1280x720 frame
    localparam int COLOR_W = 8;
    localparam int X_W = 11;
    localparam int Y_W = 10;

    // 30 LEDs need five address bits
    localparam int LED_ID_W = 5;

    // per-frame accumulator widths
    localparam int SUM_W = 32;
    localparam int CNT_W = 20;

    // counter widths for the divider steps and the decoded bits
    localparam int DIV_STEP_W = $clog2(SUM_W + 1);
    localparam int BIT_CNT_W = $clog2(LED_ID_W + 1);

    // AXI4-Lite register port
    localparam int AXI_ADDR_W = 4;
    localparam int AXI_DATA_W = 32;

    // register byte addresses
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL = 4'h0;
    localparam logic [AXI_ADDR_W-1:0] REG_THRESH = 4'h4;
    localparam logic [AXI_ADDR_W-1:0] REG_CENTROID = 4'h8;
    localparam logic [AXI_ADDR_W-1:0] REG_LED_ID = 4'hC;

    // threshold band out of reset
    localparam logic [COLOR_W-1:0] THRESH_LOWER_RST = 8'h80;
    localparam logic [COLOR_W-1:0] THRESH_UPPER_RST = 8'hFF;

    // one pixel with its coordinates attached
    typedef struct packed {
        logic               valid;
        logic               frame_last;
        logic [X_W-1:0]     x;
        logic [Y_W-1:0]     y;
        logic [COLOR_W-1:0] red;
        logic [COLOR_W-1:0] green;
        logic [COLOR_W-1:0] blue;
    } pixel_beat_t;

    // detect0 from the red band, detect1 from the blue band
    typedef struct packed {
        pixel_beat_t beat;
        logic        detect0;
        logic        detect1;
    } masked_beat_t;

    typedef struct packed {
        logic [X_W-1:0] x;
        logic [Y_W-1:0] y;
    } centroid_t;

    // settings from the register block to the pixel path
    typedef struct packed {
        logic [COLOR_W-1:0] lower;
        logic [COLOR_W-1:0] upper;
        logic               overlay_en;
        logic               cal_start;
    } cal_cfg_t;

    // results read back over AXI
    typedef struct packed {
        centroid_t           centroid;
        logic                centroid_seen;
        logic [LED_ID_W-1:0] led_id;
        logic                led_id_valid;
    } cal_status_t;

endpackage

// File: src/led_cal_regs.sv
`timescale 1ns/1ps

module led_cal_regs (
    input  logic                                  clk_pixel,
    input  logic                                  recent_reset,
    // write address and data, accepted together
    input  logic [led_cal_pkg::AXI_ADDR_W-1:0]    s_awaddr,
    input  logic                                  s_awvalid,
    output logic                                  s_awready,
    input  logic [led_cal_pkg::AXI_DATA_W-1:0]    s_wdata,
    input  logic [led_cal_pkg::AXI_DATA_W/8-1:0]  s_wstrb,
    input  logic                                  s_wvalid,
    output logic                                  s_wready,
    output logic [1:0]                            s_bresp,
    output logic                                  s_bvalid,
    input  logic                                  s_bready,
    // read address and data
    input  logic [led_cal_pkg::AXI_ADDR_W-1:0]    s_araddr,
    input  logic                                  s_arvalid,
    output logic                                  s_arready,
    output logic [led_cal_pkg::AXI_DATA_W-1:0]    s_rdata,
    output logic [1:0]                            s_rresp,
    output logic                                  s_rvalid,
    input  logic                                  s_rready,
    input  led_cal_pkg::cal_status_t              status,
    output led_cal_pkg::cal_cfg_t                 cfg
);
    import led_cal_pkg::*;

    logic                  wr_fire;
    logic                  rd_fire;
    logic [AXI_DATA_W-1:0] rd_word;

    // aw and w go in one handshake, and only when no response is pending
    assign s_awready = s_awvalid && s_wvalid && !s_bvalid;
    assign s_wready  = s_awready;
    assign wr_fire   = s_awready;

    // a held read response blocks the next address
    assign s_arready = !s_rvalid;
    assign rd_fire   = s_arvalid && s_arready;

    // every access answers OKAY
    assign s_bresp = 2'b00;
    assign s_rresp = 2'b00;

    // register writes, cal_start lives for one cycle
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            s_bvalid       <= 1'b0;
            cfg.lower      <= THRESH_LOWER_RST;
            cfg.upper      <= THRESH_UPPER_RST;
            cfg.overlay_en <= 1'b0;
            cfg.cal_start  <= 1'b0;
        end else begin
            cfg.cal_start <= 1'b0;
            if (wr_fire) begin
                s_bvalid <= 1'b1;
                case (s_awaddr)
                    REG_CTRL: begin
                        if (s_wstrb[0]) begin
                            cfg.overlay_en <= s_wdata[0];
                            cfg.cal_start  <= s_wdata[1];
                        end
                    end
                    REG_THRESH: begin
                        if (s_wstrb[0]) begin
                            cfg.lower <= s_wdata[7:0];
                        end
                        if (s_wstrb[1]) begin
                            cfg.upper <= s_wdata[15:8];
                        end
                    end
                    // read-only and unmapped addresses drop the data
                    default: ;
                endcase
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
        end
    end

    // read mux, cal_start always reads back as 0
    always_comb begin
        rd_word = '0;
        case (s_araddr)
            REG_CTRL:     rd_word[0] = cfg.overlay_en;
            REG_THRESH:   rd_word[15:0] = {cfg.upper, cfg.lower};
            REG_CENTROID: begin
                rd_word[X_W-1:0]   = status.centroid.x;
                rd_word[16+:Y_W]   = status.centroid.y;
                rd_word[31]        = status.centroid_seen;
            end
            REG_LED_ID: begin
                rd_word[LED_ID_W-1:0] = status.led_id;
                rd_word[31]           = status.led_id_valid;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            s_rvalid <= 1'b0;
        end else if (rd_fire) begin
            s_rvalid <= 1'b1;
        end else if (s_rready) begin
            s_rvalid <= 1'b0;
        end
    end

    // read data is captured with the address
    always_ff @(posedge clk_pixel) begin
        if (rd_fire) begin
            s_rdata <= rd_word;
        end
    end

    // a response needs a write behind it and stays up until taken
    assert property (@(posedge clk_pixel) disable iff (recent_reset)
        $rose(s_bvalid) |-> $past(s_awvalid && s_awready));
    assert property (@(posedge clk_pixel) disable iff (recent_reset)
        s_bvalid && !s_bready |=> s_bvalid);

endmodule

// File: src/color_threshold.sv
`timescale 1ns/1ps

module color_threshold (
    input  logic                      clk_pixel,
    input  logic                      recent_reset,
    input  led_cal_pkg::pixel_beat_t  pix_in,
    input  led_cal_pkg::cal_cfg_t     cfg,
    output led_cal_pkg::masked_beat_t masked
);

    logic red_hit;
    logic blue_hit;

    // inclusive band on both channels, same limits for each
    always_comb begin
        red_hit  = (pix_in.red >= cfg.lower) && (pix_in.red <= cfg.upper);
        blue_hit = (pix_in.blue >= cfg.lower) && (pix_in.blue <= cfg.upper);
    end

    // one stage, masks travel with their beat
    always_ff @(posedge clk_pixel) begin
        masked.beat    <= pix_in;
        // invalid beats never count as detected
        masked.detect0 <= pix_in.valid && red_hit;
        masked.detect1 <= pix_in.valid && blue_hit;
        if (recent_reset) begin
            masked.beat.valid      <= 1'b0;
            masked.beat.frame_last <= 1'b0;
            masked.detect0         <= 1'b0;
            masked.detect1         <= 1'b0;
        end
    end

endmodule

// File: src/blob_centroid.sv
`timescale 1ns/1ps

module blob_centroid (
    input  logic                      clk_pixel,
    input  logic                      recent_reset,
    input  led_cal_pkg::masked_beat_t masked,
    output led_cal_pkg::centroid_t    centroid,
    output logic                      centroid_seen,
    output logic                      done
);
    import led_cal_pkg::*;

    // restoring divider state, dividend shifts out as quotient shifts in
    typedef struct packed {
        logic [CNT_W:0]   rem;
        logic [SUM_W-1:0] quo;
    } div_state_t;

    logic [SUM_W-1:0]      sum_x;
    logic [SUM_W-1:0]      sum_y;
    logic [CNT_W-1:0]      pix_cnt;
    // totals with the current beat folded in
    logic [SUM_W-1:0]      next_x;
    logic [SUM_W-1:0]      next_y;
    logic [CNT_W-1:0]      next_cnt;
    logic                  frame_end;
    logic                  busy;
    logic [DIV_STEP_W-1:0] step_cnt;
    logic [CNT_W-1:0]      divisor;
    div_state_t            div_x;
    div_state_t            div_y;

    // one quotient bit per call
    function automatic div_state_t div_step(input div_state_t s, input logic [CNT_W-1:0] d);
        logic [CNT_W:0] trial;
        div_state_t     n;
        trial = {s.rem[CNT_W-1:0], s.quo[SUM_W-1]};
        n.quo = {s.quo[SUM_W-2:0], 1'b0};
        if (trial >= {1'b0, d}) begin
            n.rem    = trial - {1'b0, d};
            n.quo[0] = 1'b1;
        end else begin
            n.rem = trial;
        end
        return n;
    endfunction

    assign frame_end = masked.beat.valid && masked.beat.frame_last;

    always_comb begin
        next_x   = sum_x;
        next_y   = sum_y;
        next_cnt = pix_cnt;
        if (masked.detect1) begin
            next_x   = sum_x + SUM_W'(masked.beat.x);
            next_y   = sum_y + SUM_W'(masked.beat.y);
            next_cnt = pix_cnt + CNT_W'(1);
        end
    end

    // accumulators restart on every frame boundary, busy or not
    always_ff @(posedge clk_pixel) begin
        if (recent_reset || frame_end) begin
            sum_x   <= '0;
            sum_y   <= '0;
            pix_cnt <= '0;
        end else begin
            sum_x   <= next_x;
            sum_y   <= next_y;
            pix_cnt <= next_cnt;
        end
    end

    // divider sequencing and result latch
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            busy          <= 1'b0;
            step_cnt      <= '0;
            done          <= 1'b0;
            centroid      <= '0;
            centroid_seen <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                // empty frame keeps the old centroid
                if (frame_end && next_cnt != '0) begin
                    busy     <= 1'b1;
                    step_cnt <= DIV_STEP_W'(SUM_W);
                end
            end else if (step_cnt != '0) begin
                step_cnt <= step_cnt - 1'b1;
            end else begin
                busy          <= 1'b0;
                done          <= 1'b1;
                centroid_seen <= 1'b1;
                centroid.x    <= div_x.quo[X_W-1:0];
                centroid.y    <= div_y.quo[Y_W-1:0];
            end
        end
    end

    // while idle the operands track the frame totals, both axes share the divisor
    always_ff @(posedge clk_pixel) begin
        if (!busy) begin
            divisor <= next_cnt;
            div_x   <= '{rem: '0, quo: next_x};
            div_y   <= '{rem: '0, quo: next_y};
        end else if (step_cnt != '0) begin
            div_x <= div_step(div_x, divisor);
            div_y <= div_step(div_y, divisor);
        end
    end

    // pixel count must not wrap within one frame
    assert property (@(posedge clk_pixel) disable iff (recent_reset)
        masked.detect1 |-> pix_cnt != '1);

endmodule

// File: src/led_id_decoder.sv
`timescale 1ns/1ps

module led_id_decoder (
    input  logic                                clk_pixel,
    input  logic                                recent_reset,
    input  led_cal_pkg::masked_beat_t           masked,
    input  logic                                cal_start,
    output logic [led_cal_pkg::LED_ID_W-1:0]    led_id,
    output logic                                led_id_valid
);
    import led_cal_pkg::*;

    logic [CNT_W-1:0]     cnt1;
    logic [CNT_W-1:0]     cnt0;
    logic [CNT_W-1:0]     tot1;
    logic [CNT_W-1:0]     tot0;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic                 frame_end;

    assign frame_end = masked.beat.valid && masked.beat.frame_last;

    // counts including the current beat
    always_comb begin
        tot1 = cnt1 + CNT_W'(masked.detect1);
        tot0 = cnt0 + CNT_W'(masked.detect0);
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset || frame_end) begin
            cnt1 <= '0;
            cnt0 <= '0;
        end else begin
            cnt1 <= tot1;
            cnt0 <= tot0;
        end
    end

    // msb first, blue majority decodes as 1
    always_ff @(posedge clk_pixel) begin
        if (recent_reset || cal_start) begin
            led_id       <= '0;
            bit_cnt      <= '0;
            led_id_valid <= 1'b0;
        end else if (frame_end && bit_cnt < BIT_CNT_W'(LED_ID_W)) begin
            led_id  <= {led_id[LED_ID_W-2:0], tot1 > tot0};
            bit_cnt <= bit_cnt + 1'b1;
            // last bit in, id holds until the next cal_start
            if (bit_cnt == BIT_CNT_W'(LED_ID_W - 1)) begin
                led_id_valid <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk_pixel) disable iff (recent_reset)
        bit_cnt <= BIT_CNT_W'(LED_ID_W));

endmodule

// File: src/crosshair_overlay.sv
`timescale 1ns/1ps

module crosshair_overlay (
    input  logic                      clk_pixel,
    input  logic                      recent_reset,
    input  led_cal_pkg::masked_beat_t masked,
    input  led_cal_pkg::centroid_t    centroid,
    input  logic                      overlay_en,
    output led_cal_pkg::pixel_beat_t  pix_out
);

    logic on_cross;

    // centroid row or column
    assign on_cross = overlay_en &&
                      (masked.beat.x == centroid.x || masked.beat.y == centroid.y);

    always_ff @(posedge clk_pixel) begin
        pix_out <= masked.beat;
        // full scale white over the line
        if (on_cross) begin
            pix_out.red   <= '1;
            pix_out.green <= '1;
            pix_out.blue  <= '1;
        end
        if (recent_reset) begin
            pix_out.valid      <= 1'b0;
            pix_out.frame_last <= 1'b0;
        end
    end

endmodule

// File: src/led_cal_top.sv
`timescale 1ns/1ps

module led_cal_top (
    input  logic                                  clk_pixel,
    input  logic                                  recent_reset,
    input  led_cal_pkg::pixel_beat_t              pix_in,
    output led_cal_pkg::pixel_beat_t              pix_out,
    input  logic [led_cal_pkg::AXI_ADDR_W-1:0]    s_awaddr,
    input  logic                                  s_awvalid,
    output logic                                  s_awready,
    input  logic [led_cal_pkg::AXI_DATA_W-1:0]    s_wdata,
    input  logic [led_cal_pkg::AXI_DATA_W/8-1:0]  s_wstrb,
    input  logic                                  s_wvalid,
    output logic                                  s_wready,
    output logic [1:0]                            s_bresp,
    output logic                                  s_bvalid,
    input  logic                                  s_bready,
    input  logic [led_cal_pkg::AXI_ADDR_W-1:0]    s_araddr,
    input  logic                                  s_arvalid,
    output logic                                  s_arready,
    output logic [led_cal_pkg::AXI_DATA_W-1:0]    s_rdata,
    output logic [1:0]                            s_rresp,
    output logic                                  s_rvalid,
    input  logic                                  s_rready
);
    import led_cal_pkg::*;

    cal_cfg_t            cfg;
    cal_status_t         status;
    masked_beat_t        masked;
    centroid_t           centroid;
    logic                centroid_seen;
    logic [LED_ID_W-1:0] led_id;
    logic                led_id_valid;

    // results gathered for readback
    assign status = '{centroid: centroid, centroid_seen: centroid_seen,
                      led_id: led_id, led_id_valid: led_id_valid};

    led_cal_regs led_cal_regs_inst (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .s_awaddr(s_awaddr),
        .s_awvalid(s_awvalid),
        .s_awready(s_awready),
        .s_wdata(s_wdata),
        .s_wstrb(s_wstrb),
        .s_wvalid(s_wvalid),
        .s_wready(s_wready),
        .s_bresp(s_bresp),
        .s_bvalid(s_bvalid),
        .s_bready(s_bready),
        .s_araddr(s_araddr),
        .s_arvalid(s_arvalid),
        .s_arready(s_arready),
        .s_rdata(s_rdata),
        .s_rresp(s_rresp),
        .s_rvalid(s_rvalid),
        .s_rready(s_rready),
        .status(status),
        .cfg(cfg)
    );

    // stage 1 of the two-cycle pixel path
    color_threshold color_threshold_inst (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .pix_in(pix_in),
        .cfg(cfg),
        .masked(masked)
    );

    // readback relies on centroid_seen and the done pulse has no user here
    blob_centroid blob_centroid_inst (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .masked(masked),
        .centroid(centroid),
        .centroid_seen(centroid_seen),
        .done()
    );

    led_id_decoder led_id_decoder_inst (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .masked(masked),
        .cal_start(cfg.cal_start),
        .led_id(led_id),
        .led_id_valid(led_id_valid)
    );

    // stage 2
    crosshair_overlay crosshair_overlay_inst (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .masked(masked),
        .centroid(centroid),
        .overlay_en(cfg.overlay_en),
        .pix_out(pix_out)
    );

endmodule

// File: sim/tb_led_cal.sv
`timescale 1ns/1ps

module tb_led_cal;
    import led_cal_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int FRAME_W = 16;
    localparam int FRAME_H = 8;
    localparam int NUM_FRAMES = 6;
    // worst case from frame_last to the centroid update
    localparam int CENTROID_LATENCY = 34;
    localparam int SETTLE_CYCLES = CENTROID_LATENCY + 6;
    localparam int FRAME_CYCLES = FRAME_W * FRAME_H + SETTLE_CYCLES;
    localparam int AXI_OVERHEAD_CYCLES = 400;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES * 2 + AXI_OVERHEAD_CYCLES;
    localparam logic [31:0] LFSR_SEED = 32'he903_6a2e;
    // red rectangle sits in the right-hand columns
    localparam int RED_X0 = 12;

    // one table row per frame
    typedef struct packed {
        int blob_x;
        int blob_y;
        int blob_w;
        int blob_h;
        bit id_bit;
        bit empty;
        bit overlay;
    } frame_entry_t;

    logic                  clk_pixel = 1'b0;
    logic                  recent_reset;
    pixel_beat_t           pix_in;
    pixel_beat_t           pix_out;
    logic [AXI_ADDR_W-1:0] s_awaddr;
    logic                  s_awvalid;
    logic                  s_awready;
    logic [AXI_DATA_W-1:0] s_wdata;
    logic [AXI_DATA_W/8-1:0] s_wstrb;
    logic                  s_wvalid;
    logic                  s_wready;
    logic [1:0]            s_bresp;
    logic                  s_bvalid;
    logic                  s_bready;
    logic [AXI_ADDR_W-1:0] s_araddr;
    logic                  s_arvalid;
    logic                  s_arready;
    logic [AXI_DATA_W-1:0] s_rdata;
    logic [1:0]            s_rresp;
    logic                  s_rvalid;
    logic                  s_rready;

    frame_entry_t          frame_table [NUM_FRAMES];
    logic [31:0]           lfsr = LFSR_SEED;
    int                    checks = 0;
    int                    errors = 0;
    // reference model state
    logic [COLOR_W-1:0]    thr_lower = THRESH_LOWER_RST;
    logic [COLOR_W-1:0]    thr_upper = THRESH_UPPER_RST;
    logic                  ovl_on = 1'b0;
    logic [X_W-1:0]        exp_cx = '0;
    logic [Y_W-1:0]        exp_cy = '0;
    logic                  exp_seen = 1'b0;
    int                    frame_sum_x;
    int                    frame_sum_y;
    int                    frame_cnt1;
    // input beats delayed to line up with pix_out
    pixel_beat_t           beat_d1 = '0;
    pixel_beat_t           beat_d2 = '0;

    led_cal_top led_cal_top_inst (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .pix_in(pix_in),
        .pix_out(pix_out),
        .s_awaddr(s_awaddr),
        .s_awvalid(s_awvalid),
        .s_awready(s_awready),
        .s_wdata(s_wdata),
        .s_wstrb(s_wstrb),
        .s_wvalid(s_wvalid),
        .s_wready(s_wready),
        .s_bresp(s_bresp),
        .s_bvalid(s_bvalid),
        .s_bready(s_bready),
        .s_araddr(s_araddr),
        .s_arvalid(s_arvalid),
        .s_arready(s_arready),
        .s_rdata(s_rdata),
        .s_rresp(s_rresp),
        .s_rvalid(s_rvalid),
        .s_rready(s_rready)
    );

    always #(CLK_PERIOD / 2) clk_pixel = ~clk_pixel;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output int v);
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic bit in_band(input logic [COLOR_W-1:0] v);
        return v >= thr_lower && v <= thr_upper;
    endfunction

    task automatic check_equal(input logic [63:0] got, input logic [63:0] want,
                               input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t ns: %s, got %0h expected %0h", $time, what, got, want);
        end
    endtask

    // aw and w together, then wait for the response
    task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr,
                             input logic [AXI_DATA_W-1:0] data);
        @(posedge clk_pixel);
        s_awaddr  <= addr;
        s_awvalid <= 1'b1;
        s_wdata   <= data;
        s_wstrb   <= '1;
        s_wvalid  <= 1'b1;
        @(negedge clk_pixel);
        while (!s_awready) @(negedge clk_pixel);
        check_equal(s_wready, 1'b1, "wready with awready");
        @(posedge clk_pixel);
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        s_bready  <= 1'b1;
        @(negedge clk_pixel);
        while (!s_bvalid) @(negedge clk_pixel);
        check_equal(s_bresp, 2'b00, "write response");
        @(posedge clk_pixel);
        s_bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr,
                            output logic [AXI_DATA_W-1:0] data);
        @(posedge clk_pixel);
        s_araddr  <= addr;
        s_arvalid <= 1'b1;
        @(negedge clk_pixel);
        while (!s_arready) @(negedge clk_pixel);
        @(posedge clk_pixel);
        s_arvalid <= 1'b0;
        s_rready  <= 1'b1;
        // data sampled mid-cycle while rvalid is up
        @(negedge clk_pixel);
        while (!s_rvalid) @(negedge clk_pixel);
        data = s_rdata;
        check_equal(s_rresp, 2'b00, "read response");
        @(posedge clk_pixel);
        s_rready <= 1'b0;
    endtask

    // one full frame at one beat per clock, summing the in-band blue pixels
    task automatic drive_frame(input frame_entry_t e);
        pixel_beat_t b;
        int          x;
        int          y;
        int          v;
        bit          in_blue;
        bit          in_red;
        frame_sum_x = 0;
        frame_sum_y = 0;
        frame_cnt1 = 0;
        for (y = 0; y < FRAME_H; y++) begin
            for (x = 0; x < FRAME_W; x++) begin
                in_blue = !e.empty && x >= e.blob_x && x < e.blob_x + e.blob_w &&
                          y >= e.blob_y && y < e.blob_y + e.blob_h;
                // id bit 1 gets a tiny red patch, id bit 0 the whole right strip
                in_red = x >= RED_X0 && (!e.id_bit || (x < RED_X0 + 2 && y == 0));
                b.valid = 1'b1;
                b.frame_last = (x == FRAME_W - 1) && (y == FRAME_H - 1);
                b.x = X_W'(x);
                b.y = Y_W'(y);
                // background stays below the band
                draw_bits(8, v);
                b.red = COLOR_W'(v % int'(thr_lower));
                draw_bits(8, v);
                b.green = COLOR_W'(v);
                draw_bits(8, v);
                b.blue = COLOR_W'(v % int'(thr_lower));
                // first pixel of each rectangle sits exactly on the lower bound
                if (in_blue) begin
                    b.blue = (x == e.blob_x && y == e.blob_y) ? thr_lower : thr_upper;
                end
                if (in_red) begin
                    b.red = (x == RED_X0 && y == 0) ? thr_lower : thr_upper;
                end
                if (in_band(b.blue)) begin
                    frame_sum_x += x;
                    frame_sum_y += y;
                    frame_cnt1++;
                end
                @(posedge clk_pixel);
                pix_in <= b;
            end
        end
        @(posedge clk_pixel);
        pix_in <= '0;
    endtask

    // pix_out against the input from two cycles back
    always @(negedge clk_pixel) begin : out_monitor
        pixel_beat_t want;
        want = beat_d2;
        if (!recent_reset) begin
            check_equal(pix_out.valid, beat_d2.valid, "pix_out valid");
            if (beat_d2.valid) begin
                if (ovl_on && (beat_d2.x == exp_cx || beat_d2.y == exp_cy)) begin
                    want.red = '1;
                    want.green = '1;
                    want.blue = '1;
                end
                check_equal(pix_out, want, "pix_out beat");
            end
        end
        beat_d2 = beat_d1;
        beat_d1 = pix_in;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk_pixel);
        $display("Watchdog expired, the test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [AXI_DATA_W-1:0] rd;
        logic [AXI_DATA_W-1:0] exp_word;
        int                    i;
        int                    exp_id;
        int                    nbits;
        pix_in = '0;
        s_awaddr = '0;
        s_awvalid = 1'b0;
        s_wdata = '0;
        s_wstrb = '0;
        s_wvalid = 1'b0;
        s_bready = 1'b0;
        s_araddr = '0;
        s_arvalid = 1'b0;
        s_rready = 1'b0;
        recent_reset = 1'b1;
        // blob x, y, w, h, id bit, empty, overlay
        frame_table[0] = '{1, 1, 4, 3, 1'b1, 1'b0, 1'b0};
        frame_table[1] = '{3, 2, 2, 1, 1'b0, 1'b0, 1'b1};
        frame_table[2] = '{0, 0, 0, 0, 1'b0, 1'b1, 1'b1};
        frame_table[3] = '{5, 4, 6, 4, 1'b1, 1'b0, 1'b0};
        frame_table[4] = '{0, 0, 3, 5, 1'b1, 1'b0, 1'b1};
        frame_table[5] = '{7, 1, 5, 6, 1'b0, 1'b0, 1'b1};
        repeat (RESET_CYCLES) @(posedge clk_pixel);
        recent_reset <= 1'b0;
        repeat (2) @(posedge clk_pixel);

        // reset values, then read-back of a new band
        axi_read(REG_THRESH, rd);
        check_equal(rd, {16'h0, THRESH_UPPER_RST, THRESH_LOWER_RST}, "reset thresholds");
        axi_read(REG_CTRL, rd);
        check_equal(rd, 32'h0, "reset ctrl");
        axi_write(REG_THRESH, 32'h0000_C040);
        thr_lower = 8'h40;
        thr_upper = 8'hC0;
        axi_read(REG_THRESH, rd);
        check_equal(rd, 32'h0000_C040, "threshold read-back");
        // read-only register ignores the write
        axi_write(REG_CENTROID, 32'hFFFF_FFFF);
        axi_read(REG_CENTROID, rd);
        check_equal(rd, 32'h0, "centroid after write");
        axi_read(REG_LED_ID, rd);
        check_equal(rd, 32'h0, "reset led id");

        // start a calibration and confirm cal_start reads back as 0
        axi_write(REG_CTRL, 32'h2);
        axi_read(REG_CTRL, rd);
        check_equal(rd, 32'h0, "ctrl after cal_start");
        exp_id = 0;
        nbits = 0;

        for (i = 0; i < NUM_FRAMES; i++) begin
            axi_write(REG_CTRL, {31'h0, frame_table[i].overlay});
            ovl_on = frame_table[i].overlay;
            drive_frame(frame_table[i]);
            repeat (SETTLE_CYCLES) @(posedge clk_pixel);
            // model update by floor division of the blue sums
            if (frame_cnt1 > 0) begin
                exp_cx = X_W'(frame_sum_x / frame_cnt1);
                exp_cy = Y_W'(frame_sum_y / frame_cnt1);
                exp_seen = 1'b1;
            end
            // the table id bit is what the red and blue areas encode
            if (nbits < LED_ID_W) begin
                exp_id = (exp_id << 1) | int'(frame_table[i].id_bit);
                nbits++;
            end
            axi_read(REG_CENTROID, rd);
            if (exp_seen) begin
                while (!rd[31]) axi_read(REG_CENTROID, rd);
            end
            exp_word = '0;
            exp_word[X_W-1:0] = exp_cx;
            exp_word[16 +: Y_W] = exp_cy;
            exp_word[31] = exp_seen;
            check_equal(rd, exp_word, $sformatf("frame %0d centroid", i));
            // valid only once all five bits are in
            axi_read(REG_LED_ID, rd);
            exp_word = '0;
            exp_word[LED_ID_W-1:0] = LED_ID_W'(exp_id);
            exp_word[31] = (nbits == LED_ID_W);
            check_equal(rd, exp_word, $sformatf("frame %0d led id", i));
        end

        // a new calibration clears the decoded id and its valid bit
        axi_write(REG_CTRL, 32'h2);
        axi_read(REG_LED_ID, rd);
        check_equal(rd, 32'h0, "led id after cal_start");

        repeat (4) @(posedge clk_pixel);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
src/led_cal_pkg.sv
src/led_cal_regs.sv
src/color_threshold.sv
src/blob_centroid.sv
src/led_id_decoder.sv
src/crosshair_overlay.sv
src/led_cal_top.sv
sim/tb_led_cal.sv

// File: run.sh
#!/bin/sh
# build and run the led_cal testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_led_cal -o tb_led_cal

out=$(./obj_dir/tb_led_cal)
echo "$out"

echo "$out" | grep -q "SIMULATION PASSED"
